// ==== src/cd_defs.svh ====
// cd_defs: bus-wide width and CRC constants for the single-wire byte bus
`ifndef CD_DEFS_SVH
`define CD_DEFS_SVH

// bit period counter width
`define CD_PERIOD_W 16

// idle length counter width
`define CD_IDLE_W 8

// reflected CRC-16 polynomial
`define CD_CRC_POLY 16'hA001

`define CD_CRC_INIT 16'hFFFF

`endif

// ==== src/cd_bus_pkg.sv ====
// cd_bus_pkg: line timing and state machine types for the byte bus
`include "cd_defs.svh"

package cd_bus_pkg;

    typedef logic [`CD_PERIOD_W-1:0] period_t;   // cycles per bit minus one
    typedef logic [`CD_IDLE_W-1:0]   idle_len_t; // idle bit times before a frame

    typedef enum logic [1:0] {
        RX_WAIT,
        RX_BUS_IDLE,
        RX_DATA
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

// ==== src/cd_frame_pkg.sv ====
// cd_frame_pkg: data byte and CRC value types for bus frames

package cd_frame_pkg;

    // one payload byte, lsb goes first on the line
    typedef logic [7:0] byte_t;

    // running CRC-16 value
    typedef logic [15:0] crc_t;

endpackage

// ==== src/serial_crc.sv ====
// serial_crc: bit-serial reflected CRC-16, one bit per data_clk strobe
`timescale 1ns/100ps
`include "cd_defs.svh"

module serial_crc (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               clean,    // reload start value
    input  logic               data_clk, // shift one bit
    input  logic               data_in,
    output cd_frame_pkg::crc_t crc_out
);

    cd_frame_pkg::crc_t crc_next;
    logic               feedback;

    assign feedback = crc_out[0] ^ data_in; // lsb first

    always_comb begin
        crc_next = crc_out >> 1;
        if (feedback)
            crc_next = crc_next ^ `CD_CRC_POLY;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            crc_out <= `CD_CRC_INIT;
        else if (clean)
            crc_out <= `CD_CRC_INIT;
        else if (data_clk)
            crc_out <= crc_next;
    end

endmodule

// ==== src/rx_ser.sv ====
// rx_ser: dual-rate byte deserializer with bus idle detection and running CRC
`timescale 1ns/100ps
`include "cd_defs.svh"

module rx_ser (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cd_bus_pkg::period_t   period_ls,     // first byte rate
    input  cd_bus_pkg::period_t   period_hs,     // follow byte rate
    input  cd_bus_pkg::idle_len_t idle_len,
    output logic                  bus_idle,
    output logic                  tx_permit,
    input  logic                  wait_bus_idle, // force back to WAIT
    input  logic                  rx,            // already synchronized
    output cd_frame_pkg::byte_t   data,
    output cd_frame_pkg::crc_t    crc_data,
    output logic                  data_clk
);

    localparam logic [`CD_IDLE_W-1:0] BIT_NONE = '1;
    localparam logic [`CD_IDLE_W-1:0] STOP_BIT = 9;

    cd_bus_pkg::rx_state_t state;
    cd_bus_pkg::period_t   period_cnt;
    cd_bus_pkg::period_t   period_cur;
    cd_bus_pkg::period_t   half_period;
    logic [`CD_IDLE_W-1:0] bit_cnt;
    logic                  allow_data;    // inside a frame, more bytes may follow
    logic                  is_first_byte;
    logic                  inside_byte;
    logic                  mid_bit;
    logic                  sample_now;
    logic                  take_bit;
    logic                  stop_ok;
    cd_frame_pkg::byte_t   shift_reg;
    logic                  crc_clean;
    logic                  crc_data_clk;
    logic                  crc_rx;

    assign period_cur  = (inside_byte && !is_first_byte) ? period_hs : period_ls;
    assign half_period = period_cur >> 1;
    assign mid_bit     = (period_cnt == half_period);
    assign bus_idle    = (state == cd_bus_pkg::RX_BUS_IDLE);
    assign tx_permit   = bus_idle; // no arbitration yet

    assign sample_now = (state == cd_bus_pkg::RX_DATA) && mid_bit && !wait_bus_idle;
    assign take_bit   = sample_now && (bit_cnt != '0) && (bit_cnt != STOP_BIT);
    assign stop_ok    = sample_now && (bit_cnt == STOP_BIT) && rx;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= cd_bus_pkg::RX_WAIT;
            allow_data    <= 1'b0;
            bit_cnt       <= BIT_NONE;
            period_cnt    <= '0;
            is_first_byte <= 1'b1;
            inside_byte   <= 1'b0;
            data_clk      <= 1'b0;
            crc_clean     <= 1'b0;
            crc_data_clk  <= 1'b0;
            crc_rx        <= 1'b1;
        end else begin
            data_clk     <= 1'b0;
            crc_clean    <= 1'b0;
            crc_data_clk <= 1'b0;
            crc_rx       <= rx;   // lines up with crc_data_clk

            period_cnt <= period_cnt + 1'b1;
            if (period_cnt >= period_cur) begin
                period_cnt <= '0;
                bit_cnt    <= bit_cnt + 1'b1;
            end

            if (wait_bus_idle) begin
                bit_cnt    <= BIT_NONE;
                allow_data <= 1'b0;
                state      <= cd_bus_pkg::RX_WAIT;
            end else begin
                case (state)
                    cd_bus_pkg::RX_WAIT: begin
                        if (!rx) begin
                            period_cnt <= '0;
                            if (allow_data) begin // next byte of the frame
                                bit_cnt     <= '0;
                                inside_byte <= 1'b1;
                                state       <= cd_bus_pkg::RX_DATA;
                            end else begin
                                bit_cnt       <= BIT_NONE;
                                is_first_byte <= 1'b1;
                            end
                        end else begin
                            if (period_cnt == period_cur)
                                inside_byte <= 1'b0; // last bit over
                            if (bit_cnt != BIT_NONE && bit_cnt >= idle_len) begin
                                is_first_byte <= 1'b1;
                                state         <= cd_bus_pkg::RX_BUS_IDLE;
                            end
                        end
                    end

                    cd_bus_pkg::RX_BUS_IDLE: begin
                        if (!rx) begin
                            period_cnt  <= '0;
                            bit_cnt     <= '0;
                            crc_clean   <= 1'b1; // new frame
                            inside_byte <= 1'b1;
                            state       <= cd_bus_pkg::RX_DATA;
                        end
                    end

                    cd_bus_pkg::RX_DATA: begin
                        if (mid_bit) begin
                            if (bit_cnt == '0) begin
                                if (rx) begin // false start
                                    bit_cnt    <= BIT_NONE;
                                    allow_data <= 1'b0;
                                    state      <= cd_bus_pkg::RX_WAIT;
                                end
                            end else if (bit_cnt == STOP_BIT) begin
                                bit_cnt    <= BIT_NONE;
                                state      <= cd_bus_pkg::RX_WAIT;
                                allow_data <= rx; // bad stop kills the frame
                                if (rx) begin
                                    is_first_byte <= 1'b0; // rest at high rate
                                    data_clk      <= 1'b1;
                                end
                            end else begin
                                crc_data_clk <= 1'b1;
                            end
                        end
                    end

                    default: state <= cd_bus_pkg::RX_WAIT;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit)
            shift_reg <= {rx, shift_reg[7:1]}; // lsb arrives first
        if (stop_ok)
            data <= shift_reg;
    end

    serial_crc u_rx_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (crc_clean),
        .data_clk (crc_data_clk),
        .data_in  (crc_rx),
        .crc_out  (crc_data)
    );

endmodule

// ==== src/tx_ser.sv ====
// tx_ser: frame serializer, first byte at low rate and follow bytes at high rate
`timescale 1ns/100ps

module tx_ser (
    input  logic                clk,
    input  logic                reset_n,
    input  cd_bus_pkg::period_t period_ls,
    input  cd_bus_pkg::period_t period_hs,
    input  logic                tx_permit,
    input  logic                tx_load,   // one-cycle strobe
    input  cd_frame_pkg::byte_t tx_byte,
    output logic                tx_line,
    output logic                tx_busy,
    output logic                tx_next,   // start of stop bit
    output logic                tx_drop,
    output cd_frame_pkg::crc_t  tx_crc
);

    cd_bus_pkg::tx_state_t state;
    cd_bus_pkg::period_t   period_cnt;
    cd_bus_pkg::period_t   period_cur;
    logic                  period_end;
    logic [2:0]            bit_cnt;
    cd_frame_pkg::byte_t   shift_reg;
    logic                  is_first_byte;
    logic                  load_pending;
    logic                  crc_clean;
    logic                  crc_data_clk;
    logic                  crc_bit;

    assign period_cur = is_first_byte ? period_ls : period_hs;
    assign period_end = (period_cnt >= period_cur);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= cd_bus_pkg::TX_IDLE;
            period_cnt    <= '0;
            bit_cnt       <= '0;
            shift_reg     <= '0;
            is_first_byte <= 1'b1;
            load_pending  <= 1'b0;
            tx_line       <= 1'b1;
            tx_busy       <= 1'b0;
            tx_next       <= 1'b0;
            tx_drop       <= 1'b0;
            crc_clean     <= 1'b0;
            crc_data_clk  <= 1'b0;
            crc_bit       <= 1'b0;
        end else begin
            tx_next      <= 1'b0;
            tx_drop      <= 1'b0;
            crc_clean    <= 1'b0;
            crc_data_clk <= 1'b0;
            period_cnt   <= period_end ? '0 : period_cnt + 1'b1;

            case (state)
                cd_bus_pkg::TX_IDLE: begin
                    tx_line    <= 1'b1;
                    period_cnt <= '0;
                    if (tx_load) begin
                        if (tx_permit) begin
                            shift_reg     <= tx_byte;
                            is_first_byte <= 1'b1;
                            tx_line       <= 1'b0; // start bit next cycle
                            tx_busy       <= 1'b1;
                            crc_clean     <= 1'b1;
                            state         <= cd_bus_pkg::TX_START;
                        end else begin
                            tx_drop <= 1'b1;
                        end
                    end
                end

                cd_bus_pkg::TX_START, cd_bus_pkg::TX_DATA: begin
                    if (tx_load)
                        tx_drop <= 1'b1; // no room mid byte
                    if (period_end) begin
                        if (state == cd_bus_pkg::TX_DATA && bit_cnt == 3'd7) begin
                            tx_line <= 1'b1;
                            tx_next <= 1'b1;
                            state   <= cd_bus_pkg::TX_STOP;
                        end else begin
                            tx_line      <= shift_reg[0];
                            crc_bit      <= shift_reg[0];
                            crc_data_clk <= 1'b1;
                            shift_reg    <= shift_reg >> 1;
                            bit_cnt      <= (state == cd_bus_pkg::TX_START) ? 3'd0 : bit_cnt + 1'b1;
                            state        <= cd_bus_pkg::TX_DATA;
                        end
                    end
                end

                cd_bus_pkg::TX_STOP: begin
                    if (tx_load) begin // continues the frame
                        shift_reg    <= tx_byte;
                        load_pending <= 1'b1;
                    end
                    if (period_end) begin
                        load_pending <= 1'b0;
                        if (load_pending || tx_load) begin
                            is_first_byte <= 1'b0;
                            tx_line       <= 1'b0;
                            state         <= cd_bus_pkg::TX_START;
                        end else begin
                            is_first_byte <= 1'b1;
                            tx_busy       <= 1'b0;
                            state         <= cd_bus_pkg::TX_IDLE;
                        end
                    end
                end

                default: state <= cd_bus_pkg::TX_IDLE;
            endcase
        end
    end

    serial_crc u_tx_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (crc_clean),
        .data_clk (crc_data_clk),
        .data_in  (crc_bit),
        .crc_out  (tx_crc)
    );

endmodule

// ==== src/cd_phy.sv ====
// cd_phy: bus physical layer top with line synchronizer, receiver and transmitter
`timescale 1ns/100ps

module cd_phy (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rx_line,       // asynchronous bus input
    input  cd_bus_pkg::period_t   period_ls,
    input  cd_bus_pkg::period_t   period_hs,
    input  cd_bus_pkg::idle_len_t idle_len,
    input  logic                  wait_bus_idle,
    input  logic                  tx_load,
    input  cd_frame_pkg::byte_t   tx_byte,
    output logic                  tx_line,
    output logic                  tx_busy,
    output logic                  tx_next,
    output logic                  tx_drop,
    output cd_frame_pkg::crc_t    tx_crc,
    output cd_frame_pkg::byte_t   data,
    output logic                  data_clk,
    output cd_frame_pkg::crc_t    crc_data,
    output logic                  bus_idle,
    output logic                  tx_permit
);

    logic rx_meta;
    logic rx_sync;

    // two flops, idle high out of reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    rx_ser u_rx_ser (
        .clk           (clk),
        .reset_n       (reset_n),
        .period_ls     (period_ls),
        .period_hs     (period_hs),
        .idle_len      (idle_len),
        .bus_idle      (bus_idle),
        .tx_permit     (tx_permit),
        .wait_bus_idle (wait_bus_idle),
        .rx            (rx_sync),
        .data          (data),
        .crc_data      (crc_data),
        .data_clk      (data_clk)
    );

    tx_ser u_tx_ser (
        .clk       (clk),
        .reset_n   (reset_n),
        .period_ls (period_ls),
        .period_hs (period_hs),
        .tx_permit (tx_permit), // follows bus idle
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .tx_line   (tx_line),
        .tx_busy   (tx_busy),
        .tx_next   (tx_next),
        .tx_drop   (tx_drop),
        .tx_crc    (tx_crc)
    );

endmodule

// ==== verif/cd_phy_chk.sv ====
// cd_phy_chk: protocol assertions on the byte bus PHY outputs
`timescale 1ns/100ps

module cd_phy_chk (
    input logic clk,
    input logic reset_n,
    input logic data_clk,
    input logic bus_idle,
    input logic tx_line,
    input logic tx_busy
);

    // a byte only arrives while the bus is in use
    rx_not_idle: assert property (@(posedge clk) disable iff (!reset_n) !(data_clk && bus_idle))
        else $error("data_clk and bus_idle high in the same cycle");

    tx_idle_high: assert property (@(posedge clk) disable iff (!reset_n) !tx_busy |-> tx_line)
        else $error("tx_line low while the transmitter is not busy");

    rx_strobe_len: assert property (@(posedge clk) disable iff (!reset_n) data_clk |=> !data_clk)
        else $error("data_clk high for more than one cycle");

endmodule

bind cd_phy cd_phy_chk chk (
    .clk      (clk),
    .reset_n  (reset_n),
    .data_clk (data_clk),
    .bus_idle (bus_idle),
    .tx_line  (tx_line),
    .tx_busy  (tx_busy)
);

// ==== verif/tb_cd_phy.sv ====
// tb_cd_phy: table-driven loopback testbench for the byte bus PHY with a CRC model
`timescale 1ns/100ps

module tb_cd_phy;

    localparam int N_TESTS     = 7;
    localparam int TIMEOUT     = 6000; // cycles per wait
    localparam int MODE_LOOP   = 0;
    localparam int MODE_BAD    = 1;
    localparam int MODE_ABORT  = 2;
    localparam int MODE_GLITCH = 3;

    logic                  clk = 1'b0;
    logic                  reset_n = 1'b0;
    logic                  force_n = 1'b1;  // testbench side of the wired AND
    logic                  rx_line;
    cd_bus_pkg::period_t   period_ls = 16'd15;
    cd_bus_pkg::period_t   period_hs = 16'd7;
    cd_bus_pkg::idle_len_t idle_len = 8'd4;
    logic                  wait_bus_idle = 1'b0;
    logic                  tx_load = 1'b0;
    cd_frame_pkg::byte_t   tx_byte = 8'h00;
    logic                  tx_line;
    logic                  tx_busy;
    logic                  tx_next;
    logic                  tx_drop;
    cd_frame_pkg::crc_t    tx_crc;
    cd_frame_pkg::byte_t   data;
    logic                  data_clk;
    cd_frame_pkg::crc_t    crc_data;
    logic                  bus_idle;
    logic                  tx_permit;

    string                 t_name [N_TESTS];
    int                    t_mode [N_TESTS];
    int                    t_count[N_TESTS];
    logic [31:0]           t_bytes[N_TESTS]; // byte 0 in the low bits
    bit                    t_rnd  [N_TESTS];
    cd_bus_pkg::period_t   t_ls   [N_TESTS];
    cd_bus_pkg::period_t   t_hs   [N_TESTS];

    cd_frame_pkg::byte_t   exp_bytes[4];
    cd_frame_pkg::byte_t   got_bytes[$];
    cd_frame_pkg::crc_t    got_crc;
    integer                seed = 42;
    string                 cur_name;
    int                    errors = 0;
    int                    checks = 0;
    int                    test_errs = 0;
    int                    tests_run = 0;
    int                    failed_tests = 0;

    assign rx_line = tx_line & force_n;

    cd_phy dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_line       (rx_line),
        .period_ls     (period_ls),
        .period_hs     (period_hs),
        .idle_len      (idle_len),
        .wait_bus_idle (wait_bus_idle),
        .tx_load       (tx_load),
        .tx_byte       (tx_byte),
        .tx_line       (tx_line),
        .tx_busy       (tx_busy),
        .tx_next       (tx_next),
        .tx_drop       (tx_drop),
        .tx_crc        (tx_crc),
        .data          (data),
        .data_clk      (data_clk),
        .crc_data      (crc_data),
        .bus_idle      (bus_idle),
        .tx_permit     (tx_permit)
    );

    always #2 clk = ~clk;

    // received bytes, taken away from the active edge
    always @(negedge clk) begin
        if (data_clk) begin
            got_bytes.push_back(data);
            got_crc = crc_data;
        end
    end

    task automatic set_entry(input int idx, input string name, input int mode, input int count,
                             input logic [31:0] bytes, input bit rnd,
                             input cd_bus_pkg::period_t ls, input cd_bus_pkg::period_t hs);
        t_name[idx]  = name;
        t_mode[idx]  = mode;
        t_count[idx] = count;
        t_bytes[idx] = bytes;
        t_rnd[idx]   = rnd;
        t_ls[idx]    = ls;
        t_hs[idx]    = hs;
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            errors++;
            test_errs++;
        end
    endtask

    task automatic timeout_error(input string what);
        $display("ERROR %s: timeout waiting for %s", cur_name, what);
        errors++;
        test_errs++;
    endtask

    // reflected CRC-16, init all ones, data bits lsb first
    function automatic logic [15:0] crc_model(input int count);
        logic [15:0] crc;
        logic        fb;
        crc = 16'hFFFF;
        for (int i = 0; i < count; i++) begin
            for (int k = 0; k < 8; k++) begin
                fb  = crc[0] ^ exp_bytes[i][k];
                crc = {1'b0, crc[15:1]};
                if (fb)
                    crc = crc ^ 16'hA001;
            end
        end
        return crc;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (!bus_idle && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bus_idle)
            timeout_error("bus_idle");
    endtask

    task automatic wait_tx_next();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!tx_next && n < TIMEOUT);
        if (!tx_next)
            timeout_error("tx_next");
    endtask

    task automatic wait_rx_bytes(input int count);
        int n;
        n = 0;
        while (got_bytes.size() < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (got_bytes.size() < count)
            timeout_error("data_clk");
    endtask

    task automatic wait_tx_done();
        int n;
        n = 0;
        while (tx_busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx_busy)
            timeout_error("end of tx frame");
    endtask

    task automatic load_byte(input cd_frame_pkg::byte_t b);
        tx_load = 1'b1;
        tx_byte = b;
        @(negedge clk);
        tx_load = 1'b0;
    endtask

    task automatic send_frame(input int count, input bit abort);
        load_byte(exp_bytes[0]);
        if (abort) begin
            repeat (3 * (int'(period_ls) + 1)) @(negedge clk); // into the first byte
            wait_bus_idle = 1'b1;
            @(negedge clk);
            wait_bus_idle = 1'b0;
        end
        for (int i = 1; i < count; i++) begin
            wait_tx_next();
            load_byte(exp_bytes[i]);
        end
    endtask

    // one byte straight onto the line, stop bit as given
    task automatic drive_byte(input cd_frame_pkg::byte_t b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            force_n = bits[i];
            repeat (int'(period_ls) + 1) @(negedge clk);
        end
        force_n = 1'b1;
    endtask

    task automatic finish_test(input int idx);
        if (test_errs == 0) begin
            $display("test %0d %s: ok", idx, cur_name);
        end else begin
            $display("test %0d %s: %0d errors", idx, cur_name, test_errs);
            failed_tests++;
        end
        tests_run++;
    endtask

    task automatic run_entry(input int idx);
        int count;
        count     = t_count[idx];
        cur_name  = t_name[idx];
        test_errs = 0;
        for (int i = 0; i < 4; i++) begin
            if (t_rnd[idx])
                exp_bytes[i] = 8'($random(seed));
            else
                exp_bytes[i] = t_bytes[idx][8*i +: 8];
        end
        period_ls = t_ls[idx];
        period_hs = t_hs[idx];
        wait_idle();
        got_bytes.delete();
        case (t_mode[idx])
            MODE_LOOP: begin
                send_frame(count, 1'b0);
                wait_rx_bytes(count);
                wait_tx_done();
                check("byte count", count, got_bytes.size());
                for (int i = 0; i < count && i < got_bytes.size(); i++)
                    check("data", 32'(exp_bytes[i]), 32'(got_bytes[i]));
                check("crc_data", 32'(crc_model(count)), 32'(got_crc));
                check("tx_crc", 32'(crc_model(count)), 32'(tx_crc));
            end
            MODE_BAD: begin
                drive_byte(exp_bytes[0], 1'b0);
                wait_idle();
            end
            MODE_ABORT: begin
                send_frame(count, 1'b1);
                wait_tx_done();
                check("tx_permit", 0, 32'(tx_permit)); // bus not idle yet
                load_byte(exp_bytes[0]);
                check("tx_drop", 1, 32'(tx_drop));
                check("tx_line", 1, 32'(tx_line));
                repeat (4) @(negedge clk);
                check("tx_busy", 0, 32'(tx_busy));
                check("tx_line", 1, 32'(tx_line));
                wait_idle();
            end
            default: begin
                force_n = 1'b0; // glitch under half a slow bit
                repeat (int'(period_ls >> 1) - 2) @(negedge clk);
                force_n = 1'b1;
                repeat (3) @(negedge clk);
                check("bus_idle", 0, 32'(bus_idle));
                wait_idle();
            end
        endcase
        if (t_mode[idx] != MODE_LOOP)
            check("data_clk count", 0, got_bytes.size());
        finish_test(idx + 1);
    endtask

    initial begin
        set_entry(0, "single_byte",  MODE_LOOP,   1, 32'h000000A5, 1'b0, 16'd15, 16'd7);
        set_entry(1, "multi_byte",   MODE_LOOP,   4, 32'hFFC35A01, 1'b0, 16'd15, 16'd7);
        set_entry(2, "multi_random", MODE_LOOP,   3, 32'h00000000, 1'b1, 16'd23, 16'd5);
        set_entry(3, "bad_stop",     MODE_BAD,    1, 32'h0000003C, 1'b0, 16'd15, 16'd7);
        set_entry(4, "abort_permit", MODE_ABORT,  2, 32'h00005555, 1'b0, 16'd15, 16'd7);
        set_entry(5, "glitch",       MODE_GLITCH, 0, 32'h00000000, 1'b0, 16'd15, 16'd7);
        set_entry(6, "recovery",     MODE_LOOP,   2, 32'h0000F00F, 1'b0, 16'd11, 16'd4);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        cur_name  = "idle_detect";
        test_errs = 0;
        check("tx_line", 1, 32'(tx_line));
        check("tx_busy", 0, 32'(tx_busy));
        check("tx_next", 0, 32'(tx_next));
        check("tx_drop", 0, 32'(tx_drop));
        check("data_clk", 0, 32'(data_clk));
        repeat (int'(period_ls)) @(negedge clk); // still inside the first bit time
        check("bus_idle", 0, 32'(bus_idle));
        check("tx_permit", 0, 32'(tx_permit));
        wait_idle();
        check("bus_idle", 1, 32'(bus_idle));
        check("tx_permit", 1, 32'(tx_permit));
        finish_test(0);

        for (int i = 0; i < N_TESTS; i++)
            run_entry(i);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/cd_bus_pkg.sv
src/cd_frame_pkg.sv
src/serial_crc.sv
src/rx_ser.sv
src/tx_ser.sv
src/cd_phy.sv
verif/cd_phy_chk.sv
verif/tb_cd_phy.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cd_phy
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
